// File: source/calc_pkg.sv
`default_nettype none

package calc_pkg;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_OP,
        KEY_NEG,
        KEY_EQ
    } key_kind_t;

    typedef enum logic [1:0] {
        OP_LOAD,                        // operand becomes the accumulator
        OP_ADD,
        OP_SUB,
        OP_MUL
    } calc_op_t;

    typedef struct packed {
        logic      valid;               // one-cycle strobe
        key_kind_t kind;
        logic [3:0] digit;              // 0..9 on digit keys
        calc_op_t  op;                  // operator keys only
    } key_event_t;

    // key index is column * 4 + row
    function automatic key_event_t decode_key(input logic [3:0] idx);
        key_event_t evt;
        evt = '{valid: 1'b1, kind: KEY_DIGIT, digit: 4'd0, op: OP_LOAD};
        case (idx)
            4'd0, 4'd1, 4'd2:   evt.digit = idx + 4'd1;    // 1..3
            4'd4, 4'd5, 4'd6:   evt.digit = idx;           // 4..6
            4'd8, 4'd9, 4'd10:  evt.digit = idx - 4'd1;    // 7..9
            4'd3: begin
                evt.kind = KEY_OP;
                evt.op   = OP_ADD;
            end
            4'd7: begin
                evt.kind = KEY_OP;
                evt.op   = OP_SUB;
            end
            4'd11: begin
                evt.kind = KEY_OP;
                evt.op   = OP_MUL;
            end
            4'd12:   evt.kind = KEY_NEG;
            4'd13:   evt.digit = 4'd0;
            4'd14:   evt.kind = KEY_EQ;
            default: evt.valid = 1'b0;                     // key 15 does nothing
        endcase
        return evt;
    endfunction

endpackage

`default_nettype wire

// File: source/keypad_scanner.sv
`default_nettype none

module keypad_scanner import calc_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row,             // active low
    output logic [3:0] col,             // one column driven low at a time
    output key_event_t key_evt
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        S_SCAN,
        S_DEBOUNCE,
        S_EMIT,
        S_RELEASE
    } scan_state_t;

    scan_state_t state;

    logic [1:0]       col_idx;          // column currently driven
    logic [1:0]       col_nxt;
    logic             scan_live;        // col holds a real column
    logic [11:0]      row_cap;          // columns 0..2 of the running scan
    logic [15:0]      scan_mat;         // complete scan incl. column 3
    logic             scan_done;
    logic [15:0]      stable_mat;
    logic [CNT_W-1:0] stable_cnt;       // identical scans seen so far
    logic [CNT_W-1:0] cnt_next;
    logic [3:0]       press_idx;

    assign col_nxt   = col_idx + 2'd1;
    assign scan_done = scan_live && (col_idx == 2'd3);
    assign scan_mat  = {~row, row_cap};
    assign cnt_next  = stable_cnt + 1'b1;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            col       <= 4'b1111;
            col_idx   <= 2'd3;          // so column 0 comes first
            scan_live <= 1'b0;
        end else begin
            col       <= ~(4'b0001 << col_nxt);
            col_idx   <= col_nxt;
            scan_live <= 1'b1;
        end
    end

    // rows settled for a full cycle on the current column
    always_ff @(posedge clk) begin
        if (scan_live) begin
            case (col_idx)
                2'd0:    row_cap[3:0]  <= ~row;
                2'd1:    row_cap[7:4]  <= ~row;
                2'd2:    row_cap[11:8] <= ~row;
                default: ;              // column 3 read directly
            endcase
        end
    end

    // lowest pressed index wins
    always_comb begin
        press_idx = 4'd15;
        for (int i = 15; i >= 0; i--) begin
            if (stable_mat[i]) press_idx = 4'(i);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= S_SCAN;
            stable_mat <= '0;
            stable_cnt <= '0;
            key_evt    <= '0;
        end else begin
            key_evt <= '0;
            case (state)
                S_SCAN: begin
                    if (scan_done && |scan_mat) begin
                        stable_mat <= scan_mat;
                        stable_cnt <= CNT_W'(1);
                        state      <= (DEBOUNCE_CYCLES <= 1) ? S_EMIT : S_DEBOUNCE;
                    end
                end
                S_DEBOUNCE: begin
                    if (scan_done) begin
                        if (scan_mat == '0) begin
                            state <= S_SCAN;        // released during debounce
                        end else if (scan_mat != stable_mat) begin
                            stable_mat <= scan_mat;
                            stable_cnt <= CNT_W'(1);
                        end else if (cnt_next == CNT_W'(DEBOUNCE_CYCLES)) begin
                            state <= S_EMIT;
                        end else begin
                            stable_cnt <= cnt_next;
                        end
                    end
                end
                S_EMIT: begin
                    key_evt <= decode_key(press_idx);
                    state   <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (scan_done && scan_mat == '0) state <= S_SCAN;
                end
                default: state <= S_SCAN;
            endcase
        end
    end

    a_col_onehot: assert property (@(posedge clk) disable iff (!nRST)
        scan_live |-> $onehot(~col));

endmodule

`default_nettype wire

// File: source/operand_entry.sv
`default_nettype none

module operand_entry import calc_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  key_event_t               key_evt,
    output logic signed [DATA_W-1:0] operand
);

    logic [DATA_W-1:0] mag;             // digits entered so far
    logic              neg;             // sign toggled by the negate key
    logic              clr_pend;        // operand still needed by arith_unit

    logic evt_digit;
    logic evt_neg;
    logic evt_end;

    assign evt_digit = key_evt.valid && (key_evt.kind == KEY_DIGIT);
    assign evt_neg   = key_evt.valid && (key_evt.kind == KEY_NEG);
    assign evt_end   = key_evt.valid &&
                       (key_evt.kind == KEY_OP || key_evt.kind == KEY_EQ);

    /* The clear waits one cycle so that the operand is still intact
       while the sequencer's strobe is being applied downstream. */
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mag      <= '0;
            neg      <= 1'b0;
            clr_pend <= 1'b0;
        end else begin
            clr_pend <= evt_end;
            if (clr_pend) begin
                mag <= '0;
                neg <= 1'b0;
            end
            if (evt_digit) begin
                mag <= mag * DATA_W'(10) + DATA_W'(key_evt.digit);
            end
            if (evt_neg) begin
                neg <= ~neg;
            end
        end
    end

    assign operand = neg ? -$signed(mag) : $signed(mag);

endmodule

`default_nettype wire

// File: source/calc_sequencer.sv
`default_nettype none

module calc_sequencer import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  key_event_t key_evt,
    output calc_op_t   pending_op,      // operator waiting for its right operand
    output logic       accumulate,
    output logic       finish
);

    calc_op_t next_op;                  // operator just keyed in
    logic     evt_op;
    logic     evt_eq;

    assign evt_op = key_evt.valid && (key_evt.kind == KEY_OP);
    assign evt_eq = key_evt.valid && (key_evt.kind == KEY_EQ);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            accumulate <= 1'b0;
            finish     <= 1'b0;
        end else begin
            accumulate <= evt_op;
            finish     <= evt_eq;
        end
    end

    // pending_op switches only after the strobe, so the strobe
    // sees the operator that was keyed before this one
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            next_op    <= OP_LOAD;
            pending_op <= OP_LOAD;
        end else begin
            if (evt_op) begin
                next_op <= key_evt.op;
            end
            if (accumulate) begin
                pending_op <= next_op;
            end else if (finish) begin
                pending_op <= OP_LOAD;  // next operand starts fresh
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!nRST)
        !(accumulate && finish));

endmodule

`default_nettype wire

// File: source/arith_unit.sv
`default_nettype none

module arith_unit import calc_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_op_t                 pending_op,
    input  logic                     accumulate,
    input  logic                     finish,
    input  logic signed [DATA_W-1:0] operand,
    output logic signed [DATA_W-1:0] result,
    output logic                     result_valid
);

    logic signed [DATA_W-1:0] acc;
    logic signed [DATA_W-1:0] calc;     // acc <op> operand mod 2^DATA_W

    always_comb begin
        case (pending_op)
            OP_ADD:  calc = acc + operand;
            OP_SUB:  calc = acc - operand;
            OP_MUL:  calc = acc * operand;  // low half only
            default: calc = operand;        // load
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            acc          <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= finish;
            if (accumulate || finish) begin
                acc <= calc;
            end
            if (finish) begin
                result <= calc;
            end
        end
    end

    // equal events are at least a full scan apart
    a_result_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid);

endmodule

`default_nettype wire

// File: source/keypad_calc_top.sv
`default_nettype none

module keypad_calc_top import calc_pkg::*; #(
    parameter int DATA_W          = 16,
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [3:0]               row,
    output logic [3:0]               col,
    output logic signed [DATA_W-1:0] result,
    output logic                     result_valid
);

    key_event_t               key_evt;
    logic signed [DATA_W-1:0] operand;
    calc_op_t                 pending_op;
    logic                     accumulate;
    logic                     finish;

    keypad_scanner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_scanner (
        .clk     (clk),
        .nRST    (nRST),
        .row     (row),
        .col     (col),
        .key_evt (key_evt)
    );

    operand_entry #(
        .DATA_W(DATA_W)
    ) i_entry (
        .clk     (clk),
        .nRST    (nRST),
        .key_evt (key_evt),
        .operand (operand)
    );

    calc_sequencer i_seq (
        .clk        (clk),
        .nRST       (nRST),
        .key_evt    (key_evt),
        .pending_op (pending_op),
        .accumulate (accumulate),
        .finish     (finish)
    );

    arith_unit #(
        .DATA_W(DATA_W)
    ) i_arith (
        .clk          (clk),
        .nRST         (nRST),
        .pending_op   (pending_op),
        .accumulate   (accumulate),
        .finish       (finish),
        .operand      (operand),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// File: testbench/keypad_model.sv
`default_nettype none

module keypad_model (
    input  logic [3:0]  col,            // active low column drive
    input  logic [15:0] pressed,        // bit index is column * 4 + row
    output logic [3:0]  row
);

    timeunit 1ns;
    timeprecision 100ps;

    // a pressed key shorts its row to its column
    always_comb begin
        row = 4'b1111;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                if (!col[c] && pressed[c * 4 + r]) begin
                    row[r] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_keypad_calc.sv
`default_nettype none

module tb_keypad_calc import calc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 80 * 100 + 10;  // 80 presses plus reset

    logic               clk;
    logic               nRST;
    logic [3:0]         row;
    logic [3:0]         col;
    logic signed [15:0] result;
    logic               result_valid;
    logic [15:0]        pressed;            // keys held on the keypad

    int                 errors = 0;
    int                 n_events = 0;
    int                 cycles = 0;
    logic               eq_d1;
    logic               eq_d2;
    logic signed [15:0] prev_result;
    logic signed [15:0] last_result;        // value of the latest result_valid
    logic [15:0]        lfsr;

    logic signed [15:0] ref_acc;
    logic signed [15:0] ref_result;
    logic [15:0]        ref_mag;
    logic               ref_neg;
    calc_op_t           ref_op;

    int         seq_arith[12] = '{0, 1, 3, 2, 4, 5, 7, 6, 8, 11, 9, 14};    // 12+345-67*8=
    int         seq_wrap[8]   = '{10, 10, 10, 11, 10, 10, 10, 14};        // 999*999=
    int         seq_neg[5]    = '{5, 12, 3, 2, 14};                       // 5 neg + 3 =
    logic [3:0] op_keys[4]    = '{4'd3, 4'd7, 4'd11, 4'd15};

    keypad_calc_top #(
        .DATA_W          (16),
        .DEBOUNCE_CYCLES (3)
    ) i_dut (
        .clk          (clk),
        .nRST         (nRST),
        .row          (row),
        .col          (col),
        .result       (result),
        .result_valid (result_valid)
    );

    keypad_model i_keypad (
        .col     (col),
        .pressed (pressed),
        .row     (row)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic log_error(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[2:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [3:0] digit_key(input logic [3:0] d);
        case (d)
            4'd0, 4'd1, 4'd2, 4'd3: return (d == 4'd0) ? 4'd13 : d - 4'd1;
            4'd4, 4'd5, 4'd6:       return d;
            default:                return d + 4'd1;   // 7..9
        endcase
    endfunction

    // calculator behaviour straight from the keypad map
    task automatic model_key(input logic [3:0] idx);
        logic signed [15:0] opnd;
        opnd = ref_neg ? -$signed(ref_mag) : $signed(ref_mag);
        case (idx)
            4'd0, 4'd1, 4'd2:  ref_mag = ref_mag * 16'd10 + 16'(idx + 4'd1);
            4'd4, 4'd5, 4'd6:  ref_mag = ref_mag * 16'd10 + 16'(idx);
            4'd8, 4'd9, 4'd10: ref_mag = ref_mag * 16'd10 + 16'(idx - 4'd1);
            4'd13:             ref_mag = ref_mag * 16'd10;
            4'd12:             ref_neg = !ref_neg;
            4'd15:             ;                        // dead key
            default: begin                              // operator or equal
                case (ref_op)
                    OP_ADD:  ref_acc = ref_acc + opnd;
                    OP_SUB:  ref_acc = ref_acc - opnd;
                    OP_MUL:  ref_acc = ref_acc * opnd;
                    default: ref_acc = opnd;
                endcase
                case (idx)
                    4'd3:    ref_op = OP_ADD;
                    4'd7:    ref_op = OP_SUB;
                    4'd11:   ref_op = OP_MUL;
                    default: begin
                        ref_op     = OP_LOAD;
                        ref_result = ref_acc;
                    end
                endcase
                ref_mag = '0;
                ref_neg = 1'b0;
            end
        endcase
    endtask

    task automatic press(input logic [15:0] mask);
        int         start;
        logic [3:0] low;
        low = 4'd15;
        for (int i = 15; i >= 0; i--) begin
            if (mask[i]) low = 4'(i);               // lowest key wins
        end
        @(negedge clk);
        start = n_events;
        model_key(low);
        @(posedge clk);
        pressed <= mask;
        repeat (40) @(posedge clk);
        pressed <= '0;
        repeat (40) @(posedge clk);
        @(negedge clk);
        assert (n_events - start == ((low == 4'd15) ? 0 : 1))
            else log_error($sformatf("keys %h gave %0d events", mask, n_events - start));
    endtask

    task automatic expect_result(input logic signed [15:0] want);
        assert (last_result == want)
            else log_error($sformatf("directed result %0d, expected %0d", last_result, want));
    endtask

    always @(posedge clk) begin
        if (!nRST) begin
            eq_d1       <= 1'b0;
            eq_d2       <= 1'b0;
            prev_result <= '0;                      // result leaves reset at zero
        end else begin
            assert (col == 4'b1111 || $onehot(~col))
                else log_error($sformatf("col %b drives several columns", col));
            assert (result_valid == eq_d2)
                else log_error($sformatf("result_valid %b, equal two cycles ago %b",
                                         result_valid, eq_d2));
            assert (result_valid || result == prev_result)
                else log_error($sformatf("result moved to %0d without result_valid", result));
            if (result_valid) begin
                last_result = result;
                assert (result == ref_result)
                    else log_error($sformatf("result %0d, model %0d", result, ref_result));
            end
            if (i_dut.key_evt.valid) n_events++;
            eq_d1       <= i_dut.key_evt.valid && i_dut.key_evt.kind == KEY_EQ;
            eq_d2       <= eq_d1;
            prev_result <= result;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: test did not end within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [2:0] sel;
        logic [3:0] k;
        nRST       = 1'b0;
        pressed    = '0;
        lfsr       = 16'd31;
        ref_acc    = '0;
        ref_result = '0;
        ref_mag    = '0;
        ref_neg    = 1'b0;
        ref_op     = OP_LOAD;
        repeat (10) @(posedge clk);
        nRST <= 1'b1;

        foreach (seq_arith[i]) press(16'd1 << seq_arith[i]);
        expect_result(16'sd2320);
        foreach (seq_wrap[i]) press(16'd1 << seq_wrap[i]);
        expect_result(16'sd14961);                  // 998001 mod 2^16
        foreach (seq_neg[i]) press(16'd1 << seq_neg[i]);
        expect_result(-16'sd2);
        press(16'h6000);                            // digit 0 held with equal
        press(16'hC000);                            // equal and dead key together
        press(16'h8000);                            // dead key alone

        repeat (50) begin
            sel = 3'(take_bits(3));
            if (sel < 3'd4) k = digit_key(take_bits(4) % 4'd10);
            else if (sel < 3'd6) k = op_keys[2'(take_bits(2))];
            else if (sel == 3'd6) k = 4'd14;
            else k = 4'd12;
            press(16'd1 << k);
        end
        press(16'd1 << 14);                         // close the last random sequence

        $display("key events %0d, errors %0d", n_events, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/calc_pkg.sv
source/keypad_scanner.sv
source/operand_entry.sv
source/calc_sequencer.sv
source/arith_unit.sv
source/keypad_calc_top.sv
testbench/keypad_model.sv
testbench/tb_keypad_calc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_keypad_calc
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
